//--- sim.f
+incdir+verilog
verilog/ht_pkg.sv
verilog/ht_cmd_ctrl.sv
verilog/ht_data_search.sv
verilog/ht_data_insert.sv
verilog/ht_ram_arbiter.sv
verilog/ht_data_ram.sv
verilog/ht_top.sv
bench/ht_properties.sv
bench/tb_ht_top.sv

//--- run.sh
#!/bin/bash
# Build and run the hash table testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_ht_top -o tb_ht_top

status=0
out=$(./obj_dir/tb_ht_top 2>&1) || status=$?
printf '%s\n' "$out"
echo "simulation exit status: $status"
echo "$out" | grep -qx "ALL TESTS PASSED"

//--- bench/tb_ht_top.sv
`include "ht_cfg.svh"

module tb_ht_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CMDS       = 400;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 80;
  localparam int TABLE_DEPTH    = 1 << `TABLE_ADDR_WIDTH;

  logic           clk_i, rst_i, cmd_valid_i, cmd_ready_o, result_valid_o, result_ready_i;
  ht_pkg::cmd_t   cmd_i, result_cmd_o;
  ht_pkg::key_t   key_i, result_key_o;
  ht_pkg::value_t value_i, result_value_o;
  ht_pkg::res_t   result_res_o;

  logic [31:0]    lfsr_state;
  int             cycle_count;
  int             insert_count;
  logic           found_seen, no_entry_seen, full_seen;
  ht_pkg::value_t model [ht_pkg::key_t];   // key to newest value.
  ht_pkg::cmd_t   exp_cmd_q [$];
  ht_pkg::key_t   exp_key_q [$];
  ht_pkg::value_t exp_value_q [$];
  ht_pkg::res_t   exp_res_q [$];

  ht_top dut (
    .clk_i (clk_i), .rst_i (rst_i),
    .cmd_valid_i (cmd_valid_i), .cmd_ready_o (cmd_ready_o),
    .cmd_i (cmd_i), .key_i (key_i), .value_i (value_i),
    .result_valid_o (result_valid_o), .result_ready_i (result_ready_i),
    .result_cmd_o (result_cmd_o), .result_key_o (result_key_o),
    .result_value_o (result_value_o), .result_res_o (result_res_o)
  );

  bind ht_top ht_properties u_props (
    .clk_i (clk_i), .rst_i (rst_i),
    .cmd_valid_i (cmd_valid_i), .cmd_ready_o (cmd_ready_o),
    .result_valid_o (result_valid_o), .result_ready_i (result_ready_i),
    .result_cmd_o (result_cmd_o), .result_key_o (result_key_o),
    .result_value_o (result_value_o), .result_res_o (result_res_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i)
    begin
      cycle_count = cycle_count + 1;
      if (dut.u_props.error_count != 0)
        begin
          $display("a handshake assertion on the result port failed");
          $display("SOME TESTS FAILED");
          $fatal(1);
        end
      else if (cycle_count >= TIMEOUT_CYCLES)
        begin
          $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
          $display("SOME TESTS FAILED");
          $fatal(1);
        end
    end

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
      end
    return v;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_res(input string name, input ht_pkg::res_t exp, input ht_pkg::res_t got);
    if (got !== exp)
      report_mismatch(name, 32'(exp), 32'(got));
  endtask

  task automatic check_key(input string name, input ht_pkg::key_t exp, input ht_pkg::key_t got);
    if (got !== exp)
      report_mismatch(name, 32'(exp), 32'(got));
  endtask

  task automatic check_value(input string name, input ht_pkg::value_t exp,
                             input ht_pkg::value_t got);
    if (got !== exp)
      report_mismatch(name, 32'(exp), 32'(got));
  endtask

  task automatic check_cmd(input string name, input ht_pkg::cmd_t exp, input ht_pkg::cmd_t got);
    if (got !== exp)
      report_mismatch(name, 32'(exp), 32'(got));
  endtask

  // model update happens at accept, results come back in this order.
  task automatic accept_command();
    ht_pkg::res_t   res;
    ht_pkg::value_t val;
    val = value_i;
    if (cmd_i == ht_pkg::CMD_INSERT)
      begin
        if (insert_count >= TABLE_DEPTH)
          begin
            res = `RES_INSERT_FULL;
            full_seen = 1'b1;
          end
        else
          begin
            res = `RES_INSERT_OK;
            model[key_i] = value_i;
            insert_count = insert_count + 1;
          end
      end
    else if (model.exists(key_i))
      begin
        res = `RES_SEARCH_FOUND;
        val = model[key_i];
        found_seen = 1'b1;
      end
    else
      begin
        res = `RES_SEARCH_NO_ENTRY;
        val = '0;
        no_entry_seen = 1'b1;
      end
    exp_cmd_q.push_back(cmd_i);
    exp_key_q.push_back(key_i);
    exp_value_q.push_back(val);
    exp_res_q.push_back(res);
  endtask

  task automatic check_result();
    if (exp_res_q.size() == 0)
      begin
        $display("a result arrived with no command outstanding at t=%0t", $time);
        $display("SOME TESTS FAILED");
        $fatal(1);
      end
    check_cmd("result_cmd_o", exp_cmd_q.pop_front(), result_cmd_o);
    check_key("result_key_o", exp_key_q.pop_front(), result_key_o);
    check_value("result_value_o", exp_value_q.pop_front(), result_value_o);
    check_res("result_res_o", exp_res_q.pop_front(), result_res_o);
  endtask

  initial
    begin
      int   issued;
      int   accepted;
      logic taken;
      clk_i = 1'b0;
      rst_i = 1'b1;
      cmd_valid_i = 1'b0;
      cmd_i = ht_pkg::CMD_SEARCH;
      key_i = '0;
      value_i = '0;
      result_ready_i = 1'b0;
      lfsr_state = 32'h2233e11c;
      cycle_count = 0;
      insert_count = 0;
      found_seen = 1'b0;
      no_entry_seen = 1'b0;
      full_seen = 1'b0;
      issued = 0;
      accepted = 0;
      taken = 1'b0;
      repeat (5) @(posedge clk_i);
      #1 rst_i = 1'b0;
      while (accepted < NUM_CMDS || exp_res_q.size() != 0)
        begin
          @(posedge clk_i);
          #1;
          if (taken)
            cmd_valid_i = 1'b0;
          taken = 1'b0;
          result_ready_i = (take_bits(3) >= 3);   // low about 3 in 8.
          if (!cmd_valid_i && issued < NUM_CMDS)
            begin
              // first few searches hit an empty table.
              if (issued < 4 || take_bits(2) != 0)
                cmd_i = ht_pkg::CMD_SEARCH;
              else
                cmd_i = ht_pkg::CMD_INSERT;
              key_i = ht_pkg::key_t'(take_bits(5));
              value_i = ht_pkg::value_t'(take_bits(16));
              cmd_valid_i = 1'b1;
              issued = issued + 1;
            end
          @(negedge clk_i);
          if (result_valid_o && result_ready_i)
            check_result();
          if (cmd_valid_i && cmd_ready_o)
            begin
              accept_command();
              taken = 1'b1;
              accepted = accepted + 1;
            end
        end
      if (dut.u_props.error_count != 0)
        begin
          $display("%0d handshake assertions on the result port failed",
                   dut.u_props.error_count);
          $display("SOME TESTS FAILED");
          $fatal(1);
        end
      else if (found_seen && no_entry_seen && full_seen)
        begin
          $display("ALL TESTS PASSED");
          $finish;
        end
      else
        begin
          $display("stimulus did not reach found, no-entry and full results");
          $display("SOME TESTS FAILED");
          $fatal(1);
        end
    end

endmodule

//--- bench/ht_properties.sv
module ht_properties
(
  input logic           clk_i,
  input logic           rst_i,
  input logic           cmd_valid_i,
  input logic           cmd_ready_o,
  input logic           result_valid_o,
  input logic           result_ready_i,
  input ht_pkg::cmd_t   result_cmd_o,
  input ht_pkg::key_t   result_key_o,
  input ht_pkg::value_t result_value_o,
  input ht_pkg::res_t   result_res_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int   error_count = 0;
  logic pending;

  // set on accept, cleared when the result is taken.
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      pending <= 1'b0;
    else if (cmd_valid_i && cmd_ready_o)
      pending <= 1'b1;
    else if (result_valid_o && result_ready_i)
      pending <= 1'b0;

  // stalled result must hold.
  result_stable_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (result_valid_o && !result_ready_i) |=> (result_valid_o && $stable(result_cmd_o) &&
      $stable(result_key_o) && $stable(result_value_o) && $stable(result_res_o)))
    else
      begin
        $error("result changed or dropped under back-pressure");
        error_count = error_count + 1;
      end

  ready_while_result_a : assert property (@(posedge clk_i) disable iff (rst_i)
    result_valid_o |-> !cmd_ready_o)
    else
      begin
        $error("cmd_ready_o high while a result is presented");
        error_count = error_count + 1;
      end

  no_accept_pending_a : assert property (@(posedge clk_i) disable iff (rst_i)
    pending |-> !(cmd_valid_i && cmd_ready_o))
    else
      begin
        $error("command accepted while the previous result is pending");
        error_count = error_count + 1;
      end

endmodule

//--- verilog/ht_top.sv
module ht_top
(
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           cmd_valid_i,
  output logic           cmd_ready_o,
  input  ht_pkg::cmd_t   cmd_i,
  input  ht_pkg::key_t   key_i,
  input  ht_pkg::value_t value_i,
  output logic           result_valid_o,
  input  logic           result_ready_i,
  output ht_pkg::cmd_t   result_cmd_o,
  output ht_pkg::key_t   result_key_o,
  output ht_pkg::value_t result_value_o,
  output ht_pkg::res_t   result_res_o
);

  ht_pkg::key_t      task_key, s_result_key;
  ht_pkg::value_t    task_value, s_result_value;
  ht_pkg::addr_t     task_head_ptr, head_wr_ptr, rd_addr, wr_addr, ram_addr;
  ht_pkg::res_t      s_result_res, i_result_res;
  ht_pkg::ram_word_t rd_data, wr_data, ram_wdata;
  logic              task_head_ptr_val, search_run, insert_run, search_busy, insert_busy;
  logic              s_result_valid, s_result_ready, i_result_valid, i_result_ready;
  logic              head_wr, rd_avail, rd_en, rd_data_val, wr_req, wr_gnt, ram_en, ram_we;

  ht_cmd_ctrl u_cmd_ctrl (
    .clk_i (clk_i), .rst_i (rst_i),
    .cmd_valid_i (cmd_valid_i), .cmd_ready_o (cmd_ready_o),
    .cmd_i (cmd_i), .key_i (key_i), .value_i (value_i),
    .result_valid_o (result_valid_o), .result_ready_i (result_ready_i),
    .result_cmd_o (result_cmd_o), .result_key_o (result_key_o),
    .result_value_o (result_value_o), .result_res_o (result_res_o),
    .task_key_o (task_key), .task_value_o (task_value),
    .task_head_ptr_o (task_head_ptr), .task_head_ptr_val_o (task_head_ptr_val),
    .search_run_o (search_run), .insert_run_o (insert_run),
    .search_busy_i (search_busy), .insert_busy_i (insert_busy),
    .s_result_valid_i (s_result_valid), .s_result_ready_o (s_result_ready),
    .s_result_key_i (s_result_key), .s_result_value_i (s_result_value),
    .s_result_res_i (s_result_res),
    .i_result_valid_i (i_result_valid), .i_result_ready_o (i_result_ready),
    .i_result_res_i (i_result_res),
    .head_wr_i (head_wr), .head_wr_ptr_i (head_wr_ptr)
  );

  ht_data_search u_search (
    .clk_i (clk_i), .rst_i (rst_i),
    .task_key_i (task_key), .task_head_ptr_i (task_head_ptr),
    .task_head_ptr_val_i (task_head_ptr_val), .task_run_i (search_run),
    .busy_o (search_busy),
    .rd_avail_i (rd_avail), .rd_addr_o (rd_addr), .rd_en_o (rd_en),
    .rd_data_i (rd_data), .rd_data_val_i (rd_data_val),
    .result_key_o (s_result_key), .result_value_o (s_result_value),
    .result_res_o (s_result_res), .result_valid_o (s_result_valid),
    .result_ready_i (s_result_ready)
  );

  ht_data_insert u_insert (
    .clk_i (clk_i), .rst_i (rst_i),
    .task_key_i (task_key), .task_value_i (task_value),
    .task_head_ptr_i (task_head_ptr), .task_head_ptr_val_i (task_head_ptr_val),
    .task_run_i (insert_run), .busy_o (insert_busy),
    .wr_req_o (wr_req), .wr_gnt_i (wr_gnt), .wr_addr_o (wr_addr), .wr_data_o (wr_data),
    .head_wr_o (head_wr), .head_wr_ptr_o (head_wr_ptr),
    .result_res_o (i_result_res), .result_valid_o (i_result_valid),
    .result_ready_i (i_result_ready)
  );

  ht_ram_arbiter u_arbiter (
    .clk_i (clk_i), .rst_i (rst_i),
    .rd_en_i (rd_en), .rd_addr_i (rd_addr), .rd_avail_o (rd_avail),
    .wr_req_i (wr_req), .wr_addr_i (wr_addr), .wr_data_i (wr_data), .wr_gnt_o (wr_gnt),
    .rd_data_val_o (rd_data_val),
    .ram_en_o (ram_en), .ram_we_o (ram_we), .ram_addr_o (ram_addr), .ram_wdata_o (ram_wdata)
  );

  ht_data_ram u_ram (
    .clk_i (clk_i), .en_i (ram_en), .we_i (ram_we),
    .addr_i (ram_addr), .wdata_i (ram_wdata), .rdata_o (rd_data)
  );

endmodule

//--- verilog/ht_data_ram.sv
`include "ht_cfg.svh"

module ht_data_ram
(
  input  logic              clk_i,
  input  logic              en_i,
  input  logic              we_i,
  input  ht_pkg::addr_t     addr_i,
  input  ht_pkg::ram_word_t wdata_i,
  output ht_pkg::ram_word_t rdata_o
);

  localparam int DEPTH = 1 << `TABLE_ADDR_WIDTH;

  ht_pkg::ram_word_t mem [DEPTH];

  always_ff @(posedge clk_i)
    if (en_i)
      begin
        if (we_i)
          mem[addr_i] <= wdata_i;
        else
          rdata_o <= mem[addr_i];   // one cycle latency.
      end

endmodule

//--- verilog/ht_ram_arbiter.sv
module ht_ram_arbiter
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              rd_en_i,
  input  ht_pkg::addr_t     rd_addr_i,
  output logic              rd_avail_o,
  input  logic              wr_req_i,
  input  ht_pkg::addr_t     wr_addr_i,
  input  ht_pkg::ram_word_t wr_data_i,
  output logic              wr_gnt_o,
  output logic              rd_data_val_o,
  output logic              ram_en_o,
  output logic              ram_we_o,
  output ht_pkg::addr_t     ram_addr_o,
  output ht_pkg::ram_word_t ram_wdata_o
);

  logic last_rd;
  logic rd_gnt;
  logic rd_pend;

  // reader yields only when the writer waits and the reader won last.
  assign rd_avail_o = !wr_req_i || !last_rd;
  assign rd_gnt     = rd_en_i && rd_avail_o;
  assign wr_gnt_o   = wr_req_i && !rd_gnt;

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      last_rd <= 1'b0;
    else if (rd_gnt)
      last_rd <= 1'b1;
    else if (wr_gnt_o)
      last_rd <= 1'b0;

  // matches the memory read latency.
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      rd_pend <= 1'b0;
    else
      rd_pend <= rd_gnt;

  assign rd_data_val_o = rd_pend;
  assign ram_en_o      = rd_gnt || wr_gnt_o;
  assign ram_we_o      = wr_gnt_o;
  assign ram_addr_o    = wr_gnt_o ? wr_addr_i : rd_addr_i;
  assign ram_wdata_o   = wr_data_i;

endmodule

//--- verilog/ht_data_insert.sv
`include "ht_cfg.svh"

module ht_data_insert
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  ht_pkg::key_t      task_key_i,
  input  ht_pkg::value_t    task_value_i,
  input  ht_pkg::addr_t     task_head_ptr_i,
  input  logic              task_head_ptr_val_i,
  input  logic              task_run_i,
  output logic              busy_o,
  output logic              wr_req_o,
  input  logic              wr_gnt_i,
  output ht_pkg::addr_t     wr_addr_o,
  output ht_pkg::ram_word_t wr_data_o,
  output logic              head_wr_o,
  output ht_pkg::addr_t     head_wr_ptr_o,
  output ht_pkg::res_t      result_res_o,
  output logic              result_valid_o,
  input  logic              result_ready_i
);

  typedef enum logic [1:0] {
    IDLE_S,
    WRITE_S,
    REPORT_S
  } state_t;

  state_t         state, next_state;
  ht_pkg::key_t   key_q;
  ht_pkg::value_t value_q;
  ht_pkg::addr_t  next_ptr_q;
  logic           next_val_q;
  ht_pkg::res_t   res_q;
  ht_pkg::addr_t  free_addr;
  logic           full;

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      state <= IDLE_S;
    else
      state <= next_state;

  always_comb
    begin
      next_state = state;
      case (state)
        IDLE_S:   if (task_run_i) next_state = full ? REPORT_S : WRITE_S;
        WRITE_S:  if (wr_gnt_i)   next_state = REPORT_S;
        REPORT_S: if (result_valid_o && result_ready_i) next_state = IDLE_S;
        default:  next_state = IDLE_S;
      endcase
    end

  // old head becomes the next pointer of the new entry.
  always_ff @(posedge clk_i)
    if (task_run_i)
      begin
        key_q      <= task_key_i;
        value_q    <= task_value_i;
        next_ptr_q <= task_head_ptr_i;
        next_val_q <= task_head_ptr_val_i;
        res_q      <= full ? `RES_INSERT_FULL : `RES_INSERT_OK;
      end

  // addresses are handed out in order and never returned.
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      begin
        free_addr <= '0;
        full      <= 1'b0;
      end
    else if (head_wr_o)
      begin
        free_addr <= free_addr + 1'b1;
        if (free_addr == '1)
          full <= 1'b1;
      end

  always_comb
    begin
      wr_data_o = '0;
      wr_data_o[`KEY_LSB +: `KEY_WIDTH]              = key_q;
      wr_data_o[`VALUE_LSB +: `VALUE_WIDTH]          = value_q;
      wr_data_o[`NEXT_PTR_LSB +: `TABLE_ADDR_WIDTH] = next_ptr_q;
      wr_data_o[`NEXT_VAL_BIT]                       = next_val_q;
    end

  assign wr_req_o       = (state == WRITE_S);
  assign wr_addr_o      = free_addr;
  assign head_wr_o      = wr_req_o && wr_gnt_i;
  assign head_wr_ptr_o  = free_addr;
  assign result_res_o   = res_q;
  assign result_valid_o = (state == REPORT_S);
  assign busy_o         = (state != IDLE_S);

endmodule

//--- verilog/ht_data_search.sv
`include "ht_cfg.svh"

module ht_data_search
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  ht_pkg::key_t      task_key_i,
  input  ht_pkg::addr_t     task_head_ptr_i,
  input  logic              task_head_ptr_val_i,
  input  logic              task_run_i,
  output logic              busy_o,
  input  logic              rd_avail_i,
  output ht_pkg::addr_t     rd_addr_o,
  output logic              rd_en_o,
  input  ht_pkg::ram_word_t rd_data_i,
  input  logic              rd_data_val_i,
  output ht_pkg::key_t      result_key_o,
  output ht_pkg::value_t    result_value_o,
  output ht_pkg::res_t      result_res_o,
  output logic              result_valid_o,
  input  logic              result_ready_i
);

  typedef enum logic [2:0] {
    IDLE_S,
    NO_VALID_HEAD_PTR_S,
    READ_HEAD_S,
    GO_ON_CHAIN_S,
    KEY_MATCH_S,
    ON_TAIL_S
  } state_t;

  state_t         state, next_state;
  ht_pkg::key_t   key_q;
  ht_pkg::addr_t  rd_addr;
  ht_pkg::value_t found_value;
  logic           rd_wait;
  logic           reading;
  logic           key_match;
  logic           got_tail;

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      state <= IDLE_S;
    else
      state <= next_state;

  always_comb
    begin
      next_state = state;
      case (state)
        IDLE_S:
          if (task_run_i)
            next_state = task_head_ptr_val_i ? READ_HEAD_S : NO_VALID_HEAD_PTR_S;
        READ_HEAD_S, GO_ON_CHAIN_S:
          if (rd_data_val_i)
            begin
              if (key_match)
                next_state = KEY_MATCH_S;
              else if (got_tail)
                next_state = ON_TAIL_S;
              else
                next_state = GO_ON_CHAIN_S;
            end
        KEY_MATCH_S, ON_TAIL_S, NO_VALID_HEAD_PTR_S:
          if (result_valid_o && result_ready_i)
            next_state = IDLE_S;
        default:
          next_state = IDLE_S;
      endcase
    end

  assign key_match = (rd_data_i[`KEY_LSB +: `KEY_WIDTH] == key_q);
  assign got_tail  = !rd_data_i[`NEXT_VAL_BIT];

  always_ff @(posedge clk_i)
    if (task_run_i)
      key_q <= task_key_i;

  always_ff @(posedge clk_i)
    if (task_run_i)
      rd_addr <= task_head_ptr_i;
    else if (rd_data_val_i && (next_state == GO_ON_CHAIN_S))
      rd_addr <= rd_data_i[`NEXT_PTR_LSB +: `TABLE_ADDR_WIDTH];

  always_ff @(posedge clk_i)
    if (rd_data_val_i && key_match)
      found_value <= rd_data_i[`VALUE_LSB +: `VALUE_WIDTH];

  // one read outstanding per chain step.
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      rd_wait <= 1'b0;
    else if (rd_data_val_i)
      rd_wait <= 1'b0;
    else if (rd_en_o)
      rd_wait <= 1'b1;

  assign reading   = (state == READ_HEAD_S) || (state == GO_ON_CHAIN_S);
  assign rd_en_o   = reading && rd_avail_i && !rd_wait;
  assign rd_addr_o = rd_addr;

  assign result_key_o   = key_q;
  assign result_value_o = (state == KEY_MATCH_S) ? found_value : '0;
  assign result_res_o   = (state == KEY_MATCH_S) ? `RES_SEARCH_FOUND : `RES_SEARCH_NO_ENTRY;
  assign result_valid_o = (state == KEY_MATCH_S) || (state == ON_TAIL_S) ||
                          (state == NO_VALID_HEAD_PTR_S);
  assign busy_o         = (state != IDLE_S);

endmodule

//--- verilog/ht_cmd_ctrl.sv
`include "ht_cfg.svh"

module ht_cmd_ctrl
(
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           cmd_valid_i,
  output logic           cmd_ready_o,
  input  ht_pkg::cmd_t   cmd_i,
  input  ht_pkg::key_t   key_i,
  input  ht_pkg::value_t value_i,
  output logic           result_valid_o,
  input  logic           result_ready_i,
  output ht_pkg::cmd_t   result_cmd_o,
  output ht_pkg::key_t   result_key_o,
  output ht_pkg::value_t result_value_o,
  output ht_pkg::res_t   result_res_o,
  output ht_pkg::key_t   task_key_o,
  output ht_pkg::value_t task_value_o,
  output ht_pkg::addr_t  task_head_ptr_o,
  output logic           task_head_ptr_val_o,
  output logic           search_run_o,
  output logic           insert_run_o,
  input  logic           search_busy_i,
  input  logic           insert_busy_i,
  input  logic           s_result_valid_i,
  output logic           s_result_ready_o,
  input  ht_pkg::key_t   s_result_key_i,
  input  ht_pkg::value_t s_result_value_i,
  input  ht_pkg::res_t   s_result_res_i,
  input  logic           i_result_valid_i,
  output logic           i_result_ready_o,
  input  ht_pkg::res_t   i_result_res_i,
  input  logic           head_wr_i,
  input  ht_pkg::addr_t  head_wr_ptr_i
);

  localparam int BUCKETS = 1 << `BUCKET_WIDTH;

  typedef enum logic [1:0] {
    IDLE_S,
    DISPATCH_S,
    WAIT_S
  } state_t;

  state_t          state, next_state;
  ht_pkg::cmd_t    cmd_q;
  ht_pkg::key_t    key_q;
  ht_pkg::value_t  value_q;
  ht_pkg::bucket_t bucket_q, bucket_in;
  ht_pkg::addr_t   head_ptr_q;
  logic            head_val_q;
  ht_pkg::addr_t   head_ptr [BUCKETS];
  logic [BUCKETS-1:0] head_val;
  logic            is_search, run, done;

  // xor-fold of all key bits down to the bucket index.
  function automatic ht_pkg::bucket_t hash_key(input ht_pkg::key_t key);
    ht_pkg::bucket_t h;
    h = '0;
    for (int i = 0; i < `KEY_WIDTH; i++)
      h[i % `BUCKET_WIDTH] = h[i % `BUCKET_WIDTH] ^ key[i];
    return h;
  endfunction

  assign bucket_in   = hash_key(key_i);
  assign cmd_ready_o = (state == IDLE_S);
  assign is_search   = (cmd_q == ht_pkg::CMD_SEARCH);
  assign run         = (state == DISPATCH_S) && !(is_search ? search_busy_i : insert_busy_i);
  assign done        = result_valid_o && result_ready_i;

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      state <= IDLE_S;
    else
      state <= next_state;

  always_comb
    begin
      next_state = state;
      case (state)
        IDLE_S:     if (cmd_valid_i) next_state = DISPATCH_S;
        DISPATCH_S: if (run)         next_state = WAIT_S;
        WAIT_S:     if (done)        next_state = IDLE_S;
        default:                     next_state = IDLE_S;
      endcase
    end

  // command and head lookup are registered on accept.
  always_ff @(posedge clk_i)
    if (cmd_valid_i && cmd_ready_o)
      begin
        cmd_q      <= cmd_i;
        key_q      <= key_i;
        value_q    <= value_i;
        bucket_q   <= bucket_in;
        head_ptr_q <= head_ptr[bucket_in];
        head_val_q <= head_val[bucket_in];
      end

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      head_val <= '0;
    else
      if (head_wr_i)
        head_val[bucket_q] <= 1'b1;

  always_ff @(posedge clk_i)
    if (head_wr_i)
      head_ptr[bucket_q] <= head_wr_ptr_i;

  assign task_key_o          = key_q;
  assign task_value_o        = value_q;
  assign task_head_ptr_o     = head_ptr_q;
  assign task_head_ptr_val_o = head_val_q;
  assign search_run_o        = run && is_search;
  assign insert_run_o        = run && !is_search;

  assign result_valid_o   = (state == WAIT_S) && (is_search ? s_result_valid_i : i_result_valid_i);
  assign s_result_ready_o = (state == WAIT_S) && is_search && result_ready_i;
  assign i_result_ready_o = (state == WAIT_S) && !is_search && result_ready_i;
  assign result_cmd_o     = cmd_q;
  assign result_key_o     = is_search ? s_result_key_i : key_q;
  assign result_value_o   = is_search ? s_result_value_i : value_q;   // insert echoes its value.
  assign result_res_o     = is_search ? s_result_res_i : i_result_res_i;

endmodule

//--- verilog/ht_pkg.sv
`include "ht_cfg.svh"

package ht_pkg;

  typedef logic [`KEY_WIDTH-1:0]        key_t;
  typedef logic [`VALUE_WIDTH-1:0]      value_t;
  typedef logic [`TABLE_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`BUCKET_WIDTH-1:0]     bucket_t;
  typedef logic [`RAM_WORD_WIDTH-1:0]   ram_word_t;   // 38 bits.
  typedef logic [1:0]                   res_t;

  typedef enum logic {
    CMD_SEARCH = 1'b0,
    CMD_INSERT = 1'b1
  } cmd_t;

endpackage

//--- verilog/ht_cfg.svh
`ifndef HT_CFG_SVH
`define HT_CFG_SVH

`define KEY_WIDTH        16
`define VALUE_WIDTH      16
`define TABLE_ADDR_WIDTH 5
`define BUCKET_WIDTH     3

// memory word, msb first: key, value, next ptr, next valid.
`define NEXT_VAL_BIT     0
`define NEXT_PTR_LSB     1
`define VALUE_LSB        (`NEXT_PTR_LSB + `TABLE_ADDR_WIDTH)
`define KEY_LSB          (`VALUE_LSB + `VALUE_WIDTH)
`define RAM_WORD_WIDTH   (`KEY_LSB + `KEY_WIDTH)

`define RES_SEARCH_FOUND    2'd0
`define RES_SEARCH_NO_ENTRY 2'd1
`define RES_INSERT_OK       2'd2
`define RES_INSERT_FULL     2'd3

`endif
